// ==== project.f ====
verilog/bus_side_pkg.sv
verilog/user_side_pkg.sv
verilog/sync_fifo.sv
verilog/wreq_issue.sv
verilog/beat_packer.sv
verilog/wrsp_tracker.sv
verilog/m_axi_store.sv
verif/tb_m_axi_store.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_m_axi_store -f project.f -o sim_tb

./obj_dir/sim_tb

// ==== verif/tb_m_axi_store.sv ====
`timescale 1ns/1ps

module tb_m_axi_store import bus_side_pkg::*, user_side_pkg::*;;

    localparam int TIMEOUT = 2000;

    logic       ACLK = 1'b0;
    logic       ARESET;
    user_addr_t user_awaddr;
    user_len_t  user_awlen;
    logic       user_awvalid;
    logic       user_awready;
    user_data_t user_wdata;
    user_strb_t user_wstrb;
    logic       user_wvalid;
    logic       user_wready;
    logic       user_bvalid;
    logic       user_bready = 1'b0;
    bus_addr_t  bus_awaddr;
    bus_len_t   bus_awlen;
    logic       bus_awvalid;
    logic       bus_awready = 1'b0;
    bus_data_t  bus_wdata;
    bus_strb_t  bus_wstrb;
    logic       bus_wvalid;
    logic       bus_wready = 1'b0;
    logic       bus_bvalid = 1'b0;
    logic       bus_bready;

    // expected traffic filled by the tests and drained by the bus model
    logic [31:0] exp_awaddr [$];
    logic [31:0] exp_awlen [$];
    logic [31:0] exp_wdata [$];
    logic [3:0]  exp_wstrb [$];
    logic        pend_types [$];
    int          burst_beats [$];
    user_data_t  wbuf [0:127];
    user_strb_t  sbuf [0:127];

    int          beats_seen = 0;
    int          bresp_pending = 0;
    int          bresp_count = 0;
    int          valid_resps = 0;
    logic        stall_on = 1'b0;
    logic [31:0] rng = 32'd92;

    m_axi_store #(
        .TARGET_ADDR (32'h0000_1000)
    ) UUT (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .user_awaddr  (user_awaddr),
        .user_awlen   (user_awlen),
        .user_awvalid (user_awvalid),
        .user_awready (user_awready),
        .user_wdata   (user_wdata),
        .user_wstrb   (user_wstrb),
        .user_wvalid  (user_wvalid),
        .user_wready  (user_wready),
        .user_bvalid  (user_bvalid),
        .user_bready  (user_bready),
        .bus_awaddr   (bus_awaddr),
        .bus_awlen    (bus_awlen),
        .bus_awvalid  (bus_awvalid),
        .bus_awready  (bus_awready),
        .bus_wdata    (bus_wdata),
        .bus_wstrb    (bus_wstrb),
        .bus_wvalid   (bus_wvalid),
        .bus_wready   (bus_wready),
        .bus_bvalid   (bus_bvalid),
        .bus_bready   (bus_bready)
    );

    always #2 ACLK = ~ACLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("FAIL: see errors above");
        $fatal(1, why);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR: %0t ns %s: got %h, expected %h", $time, what, got, exp);
            stop_with_failure("value mismatch");
        end
    endtask

    // ==============================
    // bus slave model and response monitor
    always @(negedge ACLK) begin
        rng = xorshift32(rng);
        bus_awready = !stall_on || (rng[1:0] != 2'b00);
        bus_wready  = !stall_on || (rng[5:4] != 2'b00);
        user_bready = !stall_on || (rng[9:8] != 2'b00);
        bus_bvalid  = (bresp_pending != 0);
    end

    always @(posedge ACLK) begin : bus_model
        logic was_valid;
        if (!ARESET) begin
            if (user_bvalid && user_bready) begin
                if (pend_types.size() == 0) begin
                    stop_with_failure("user response arrived with no request outstanding");
                end else begin
                    was_valid = pend_types.pop_front();
                    if (was_valid) begin
                        check_equal((bresp_count > valid_resps) ? 32'd1 : 32'd0, 32'd1,
                                    "user response ahead of bus response");
                        valid_resps++;
                    end
                end
            end
            if (bus_bvalid && bus_bready) begin
                bresp_pending--;
                bresp_count++;
            end
            if (bus_awvalid && bus_awready) begin
                if (exp_awaddr.size() == 0) begin
                    stop_with_failure("address beat appeared with none expected");
                end else begin
                    check_equal(bus_awaddr, exp_awaddr.pop_front(), "bus_awaddr");
                    check_equal(bus_awlen, exp_awlen.pop_front(), "bus_awlen");
                    burst_beats.push_back(int'((bus_awlen + (bus_awaddr & 32'd3)) >> 2) + 1);
                end
            end
            if (bus_wvalid && bus_wready) begin
                if (exp_wdata.size() == 0 || burst_beats.size() == 0) begin
                    stop_with_failure("data beat appeared with none expected");
                end else begin
                    check_equal(bus_wdata, exp_wdata.pop_front(), "bus_wdata");
                    check_equal(32'(bus_wstrb), 32'(exp_wstrb.pop_front()), "bus_wstrb");
                    beats_seen++;
                    if (beats_seen == burst_beats[0]) begin
                        void'(burst_beats.pop_front());
                        beats_seen = 0;
                        bresp_pending++;
                    end
                end
            end
        end
    end

    // ==============================
    // user side drivers
    task automatic put_request(input logic [31:0] waddr, input logic [31:0] wlen);
        int t;
        @(negedge ACLK);
        user_awaddr  = waddr;
        user_awlen   = wlen;
        user_awvalid = 1'b1;
        t = 0;
        while (!user_awready) begin
            @(negedge ACLK);
            t++;
            if (t > TIMEOUT) stop_with_failure("timed out waiting for user_awready");
        end
        @(negedge ACLK);
        user_awvalid = 1'b0;
        pend_types.push_back((wlen != 0) && !wlen[31]);
    endtask

    task automatic put_words(input int base, input int count);
        int t;
        @(negedge ACLK);
        for (int i = 0; i < count; i++) begin
            user_wdata  = wbuf[base + i];
            user_wstrb  = sbuf[base + i];
            user_wvalid = 1'b1;
            t = 0;
            while (!user_wready) begin
                @(negedge ACLK);
                t++;
                if (t > TIMEOUT) stop_with_failure("timed out waiting for user_wready");
            end
            @(negedge ACLK);
        end
        user_wvalid = 1'b0;
    endtask

    // expected bus beats with zero pads and words filling lanes low first
    task automatic expect_burst(input int waddr, input int wlen, input int base);
        logic [31:0] baddr;
        logic [31:0] data;
        logic [3:0]  strb;
        int          start;
        int          nbeats;
        int          k;
        baddr  = 32'h0000_1000 + 32'(waddr * 2);
        start  = int'(baddr[1]);
        nbeats = (start + wlen + 1) / 2;
        exp_awaddr.push_back(baddr);
        exp_awlen.push_back(32'(wlen * 2 - 1));
        for (int b = 0; b < nbeats; b++) begin
            data = '0;
            strb = '0;
            for (int lane = 0; lane < 2; lane++) begin
                k = b * 2 + lane - start;
                if (k >= 0 && k < wlen) begin
                    data[lane*16 +: 16] = wbuf[base + k];
                    strb[lane*2 +: 2]   = sbuf[base + k];
                end
            end
            exp_wdata.push_back(data);
            exp_wstrb.push_back(strb);
        end
    endtask

    task automatic fill_words(input int base, input int count);
        for (int i = base; i < base + count; i++) begin
            wbuf[i] = 16'((i * 397) ^ 16'h5a3c);
            sbuf[i] = 2'((i % 3) + 1);
        end
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (exp_awaddr.size() != 0 || exp_wdata.size() != 0 || pend_types.size() != 0) begin
            @(negedge ACLK);
            t++;
            if (t > TIMEOUT) stop_with_failure("timed out waiting for bursts and responses");
        end
        check_equal(32'(user_bvalid), 32'd0, "user_bvalid with every request answered");
    endtask

    task automatic idle_after_reset();
        check_equal(32'(bus_awvalid), 32'd0, "bus_awvalid in reset");
        check_equal(32'(bus_wvalid), 32'd0, "bus_wvalid in reset");
        check_equal(32'(user_bvalid), 32'd0, "user_bvalid in reset");
        check_equal(32'(user_awready), 32'd1, "user_awready in reset");
        check_equal(32'(user_wready), 32'd1, "user_wready in reset");
        check_equal(32'(bus_bready), 32'd0, "bus_bready in reset");
    endtask

    // ==============================
    // directed tests
    task automatic aligned_burst();
        wbuf[0] = 16'h1111;
        wbuf[1] = 16'h2222;
        wbuf[2] = 16'h3333;
        wbuf[3] = 16'h4444;
        for (int i = 0; i < 4; i++) sbuf[i] = 2'b11;
        exp_awaddr.push_back(32'h0000_1008);
        exp_awlen.push_back(32'd7);
        exp_wdata.push_back(32'h2222_1111);
        exp_wstrb.push_back(4'b1111);
        exp_wdata.push_back(32'h4444_3333);
        exp_wstrb.push_back(4'b1111);
        put_request(32'd4, 32'd4);
        put_words(0, 4);
        wait_drained();
    endtask

    task automatic odd_start_burst();
        wbuf[0] = 16'haaaa;
        wbuf[1] = 16'hbbbb;
        sbuf[0] = 2'b11;
        sbuf[1] = 2'b11;
        exp_awaddr.push_back(32'h0000_1006);
        exp_awlen.push_back(32'd3);
        exp_wdata.push_back(32'haaaa_0000);
        exp_wstrb.push_back(4'b1100);
        exp_wdata.push_back(32'h0000_bbbb);
        exp_wstrb.push_back(4'b0011);
        put_request(32'd3, 32'd2);
        put_words(0, 2);
        wait_drained();
    endtask

    task automatic invalid_lengths();
        put_request(32'd8, 32'd0);
        put_request(32'd5, 32'h8000_0004);
        wait_drained();
    endtask

    task automatic random_stalls();
        int addrs [6];
        int lens [6];
        int bases [6];
        addrs = '{0, 7, 10, 21, 2, 33};
        lens  = '{5, 3, 1, 8, 6, 2};
        bases = '{0, 8, 16, 24, 40, 56};
        stall_on = 1'b1;
        for (int r = 0; r < 6; r++) begin
            fill_words(bases[r], lens[r]);
            expect_burst(addrs[r], lens[r], bases[r]);
            put_request(32'(addrs[r]), 32'(lens[r]));
        end
        for (int r = 0; r < 6; r++) begin
            put_words(bases[r], lens[r]);
        end
        wait_drained();
    endtask

    task automatic mixed_requests();
        stall_on = 1'b1;
        fill_words(64, 4);
        expect_burst(13, 4, 64);
        put_request(32'd13, 32'd4);
        put_words(64, 4);
        put_request(32'd2, 32'd0);
        fill_words(72, 1);
        expect_burst(9, 1, 72);
        put_request(32'd9, 32'd1);
        put_words(72, 1);
        put_request(32'd6, 32'hffff_fff0);
        put_request(32'd1, 32'd0);
        fill_words(80, 7);
        expect_burst(40, 7, 80);
        put_request(32'd40, 32'd7);
        put_words(80, 7);
        wait_drained();
    endtask

    initial begin
        ARESET       = 1'b1;
        user_awaddr  = '0;
        user_awlen   = '0;
        user_awvalid = 1'b0;
        user_wdata   = '0;
        user_wstrb   = '0;
        user_wvalid  = 1'b0;
        repeat (16) @(negedge ACLK);
        idle_after_reset();
        ARESET = 1'b0;
        aligned_burst();
        odd_start_burst();
        invalid_lengths();
        random_stalls();
        mixed_requests();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== verilog/beat_packer.sv ====
`timescale 1ns/1ps

module beat_packer import bus_side_pkg::*, user_side_pkg::*; #(
    parameter int NUM_OUTSTANDING = 2,
    parameter int WBUFF_DEPTH     = 32
) (
    input  logic       ACLK,
    input  logic       ARESET,
    input  bus_addr_t  aw_addr,
    input  bus_len_t   aw_len,
    input  logic       aw_fire,
    output logic       offset_room,
    input  user_data_t user_wdata,
    input  user_strb_t user_wstrb,
    input  logic       user_wvalid,
    output logic       user_wready,
    output bus_data_t  bus_wdata,
    output bus_strb_t  bus_wstrb,
    output logic       bus_wvalid,
    input  logic       bus_wready
);

    localparam int OFS_W = 2 * PAD_ALIGN + $bits(beat_cnt_t);

    bus_addr_t       aw_end;
    bus_len_t        beat_sum;
    pad_idx_t        start_off;
    pad_idx_t        end_pad;
    beat_cnt_t       beat_total;
    logic            offset_valid;
    logic            next_offset;
    pad_idx_t        head_off;
    pad_idx_t        tail_pad;
    beat_cnt_t       beat_last;
    user_data_t      buf_data;
    user_strb_t      buf_strb;
    logic            buf_valid;
    beat_cnt_t       beat_cnt;
    logic [PADS-1:0] lane_oh;
    logic [PADS-1:0] lane_oh_q;
    logic [PADS-1:0] head_oh;
    logic [PADS-1:0] head_mask;
    logic [PADS-1:0] tail_mask;
    logic            first_lane;
    logic            last_lane;
    logic            first_beat;
    logic            last_beat;
    logic            ready_for_data;
    logic            next_lane;
    logic            next_beat;
    bus_data_t       data_q;
    bus_strb_t       strb_q;
    logic            data_valid;

    // ============================
    // per-burst offsets
    assign aw_end     = aw_addr + aw_len;
    assign beat_sum   = aw_len + bus_len_t'(aw_addr[BUS_ALIGN-1:0]);
    assign start_off  = aw_addr[BUS_ALIGN-1:USER_ALIGN];
    assign end_pad    = ~aw_end[BUS_ALIGN-1:USER_ALIGN];
    assign beat_total = beat_sum[31:BUS_ALIGN];

    sync_fifo #(.WIDTH(OFS_W), .DEPTH(NUM_OUTSTANDING)) u_offset_q (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr      (aw_fire),
        .din     ({start_off, end_pad, beat_total}),
        .full_n  (offset_room),
        .rd      (next_offset),
        .dout    ({head_off, tail_pad, beat_last}),
        .empty_n (offset_valid)
    );

    sync_fifo #(.WIDTH(USER_BYTES + USER_DW), .DEPTH(WBUFF_DEPTH)) u_data_buf (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr      (user_wvalid && user_wready),
        .din     ({user_wstrb, user_wdata}),
        .full_n  (user_wready),
        .rd      (next_lane),
        .dout    ({buf_strb, buf_data}),
        .empty_n (buf_valid)
    );

    // ============================
    // lane and beat stepping
    assign ready_for_data = !data_valid || bus_wready;
    assign first_beat     = offset_valid && (beat_cnt == '0);
    assign last_beat      = offset_valid && (beat_cnt == beat_last);
    assign next_lane      = offset_valid && buf_valid && ready_for_data;
    assign next_beat      = next_lane && last_lane;
    assign next_offset    = last_beat && next_beat;
    // last beat ends early by the tail pad count
    assign last_lane      = last_beat ? lane_oh[PADS - 1 - int'(tail_pad)] : lane_oh[PADS-1];

    always_comb begin
        for (int i = 0; i < PADS; i++) begin
            head_oh[i]   = (i == int'(head_off));
            head_mask[i] = first_beat && (i < int'(head_off));
            tail_mask[i] = last_beat && (i >= PADS - int'(tail_pad));
        end
    end

    always_comb begin
        if (!buf_valid || !offset_valid) begin
            lane_oh = '0;
        end else if (first_lane && first_beat) begin
            lane_oh = head_oh;
        end else if (first_lane) begin
            lane_oh = {{(PADS-1){1'b0}}, 1'b1};
        end else begin
            lane_oh = lane_oh_q;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            beat_cnt   <= '0;
            first_lane <= 1'b1;
            lane_oh_q  <= '0;
            data_valid <= 1'b0;
        end else begin
            if (next_offset) begin
                beat_cnt <= '0;
            end else if (next_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (next_lane) begin
                first_lane <= last_lane;
                lane_oh_q  <= lane_oh << 1;
            end
            if (next_beat) begin
                data_valid <= 1'b1;
            end else if (ready_for_data) begin
                data_valid <= 1'b0;
            end
        end
    end

    // pad lanes win over data
    always_ff @(posedge ACLK) begin
        if (ready_for_data) begin
            for (int i = 0; i < PADS; i++) begin
                if (head_mask[i] || tail_mask[i]) begin
                    data_q[i*USER_DW +: USER_DW]       <= '0;
                    strb_q[i*USER_BYTES +: USER_BYTES] <= '0;
                end else if (lane_oh[i]) begin
                    data_q[i*USER_DW +: USER_DW]       <= buf_data;
                    strb_q[i*USER_BYTES +: USER_BYTES] <= buf_strb;
                end
            end
        end
    end

    assign bus_wdata  = data_q;
    assign bus_wstrb  = strb_q;
    assign bus_wvalid = data_valid;

    a_w_hold: assert property (@(posedge ACLK) disable iff (ARESET)
        bus_wvalid && !bus_wready |=> bus_wvalid && $stable(bus_wdata) && $stable(bus_wstrb))
        else $error("data beat changed while stalled");

endmodule

// ==== verilog/bus_side_pkg.sv ====
package bus_side_pkg;

    // byte addressed 32-bit memory bus
    localparam int BUS_DW    = 32;
    localparam int BUS_BYTES = BUS_DW / 8;
    localparam int BUS_ALIGN = $clog2(BUS_BYTES);

    typedef logic [31:0]           bus_addr_t;
    // byte length minus one
    typedef logic [31:0]           bus_len_t;
    typedef logic [BUS_DW-1:0]     bus_data_t;
    typedef logic [BUS_BYTES-1:0]  bus_strb_t;

    // beats per burst minus one
    typedef logic [31-BUS_ALIGN:0] beat_cnt_t;

endpackage

// ==== verilog/m_axi_store.sv ====
`timescale 1ns/1ps

module m_axi_store import bus_side_pkg::*, user_side_pkg::*; #(
    parameter bus_addr_t TARGET_ADDR     = 32'h0,
    parameter int        MAX_REQS        = 16,
    parameter int        NUM_OUTSTANDING = 2,
    parameter int        WBUFF_DEPTH     = 32
) (
    input  logic       ACLK,
    input  logic       ARESET,
    // user request, data and response
    input  user_addr_t user_awaddr,
    input  user_len_t  user_awlen,
    input  logic       user_awvalid,
    output logic       user_awready,
    input  user_data_t user_wdata,
    input  user_strb_t user_wstrb,
    input  logic       user_wvalid,
    output logic       user_wready,
    output logic       user_bvalid,
    input  logic       user_bready,
    // memory bus
    output bus_addr_t  bus_awaddr,
    output bus_len_t   bus_awlen,
    output logic       bus_awvalid,
    input  logic       bus_awready,
    output bus_data_t  bus_wdata,
    output bus_strb_t  bus_wstrb,
    output logic       bus_wvalid,
    input  logic       bus_wready,
    input  logic       bus_bvalid,
    output logic       bus_bready
);

    logic type_ready;
    logic type_push;
    logic type_valid;
    logic offset_room;
    logic aw_fire;

    wreq_issue #(
        .TARGET_ADDR  (TARGET_ADDR),
        .MAX_REQS     (MAX_REQS)
    ) u_wreq_issue (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .user_awaddr  (user_awaddr),
        .user_awlen   (user_awlen),
        .user_awvalid (user_awvalid),
        .user_awready (user_awready),
        .type_ready   (type_ready),
        .type_push    (type_push),
        .type_valid   (type_valid),
        .offset_room  (offset_room),
        .aw_addr      (bus_awaddr),
        .aw_len       (bus_awlen),
        .aw_fire      (aw_fire),
        .bus_awvalid  (bus_awvalid),
        .bus_awready  (bus_awready)
    );

    beat_packer #(
        .NUM_OUTSTANDING (NUM_OUTSTANDING),
        .WBUFF_DEPTH     (WBUFF_DEPTH)
    ) u_beat_packer (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .aw_addr     (bus_awaddr),
        .aw_len      (bus_awlen),
        .aw_fire     (aw_fire),
        .offset_room (offset_room),
        .user_wdata  (user_wdata),
        .user_wstrb  (user_wstrb),
        .user_wvalid (user_wvalid),
        .user_wready (user_wready),
        .bus_wdata   (bus_wdata),
        .bus_wstrb   (bus_wstrb),
        .bus_wvalid  (bus_wvalid),
        .bus_wready  (bus_wready)
    );

    wrsp_tracker #(
        .NUM_OUTSTANDING (NUM_OUTSTANDING)
    ) u_wrsp_tracker (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .type_push   (type_push),
        .type_valid  (type_valid),
        .type_ready  (type_ready),
        .bus_bvalid  (bus_bvalid),
        .bus_bready  (bus_bready),
        .user_bvalid (user_bvalid),
        .user_bready (user_bready)
    );

endmodule

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             ACLK,
    input  logic             ARESET,
    input  logic             wr,
    input  logic [WIDTH-1:0] din,
    output logic             full_n,
    input  logic             rd,
    output logic [WIDTH-1:0] dout,
    output logic             empty_n
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign full_n  = (count != CNT_W'(DEPTH));
    assign empty_n = (count != '0);
    assign push    = wr && full_n;
    assign pop     = rd && empty_n;
    // first word falls through
    assign dout    = mem[rd_ptr];

    always_ff @(posedge ACLK) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // callers gate their strobes with the flags
    a_no_overflow: assert property (@(posedge ACLK) disable iff (ARESET) wr |-> full_n)
        else $error("sync_fifo write while full");
    a_no_underflow: assert property (@(posedge ACLK) disable iff (ARESET) rd |-> empty_n)
        else $error("sync_fifo read while empty");

endmodule

// ==== verilog/user_side_pkg.sv ====
package user_side_pkg;

    // word addressed user core side
    localparam int USER_DW    = 16;
    localparam int USER_BYTES = USER_DW / 8;
    localparam int USER_ALIGN = $clog2(USER_BYTES);

    // user words per bus beat
    localparam int PADS      = 2;
    localparam int PAD_ALIGN = $clog2(PADS);

    typedef logic [31:0]           user_addr_t;
    typedef logic [31:0]           user_len_t;
    typedef logic [USER_DW-1:0]    user_data_t;
    typedef logic [USER_BYTES-1:0] user_strb_t;
    typedef logic [PAD_ALIGN-1:0]  pad_idx_t;

endpackage

// ==== verilog/wreq_issue.sv ====
`timescale 1ns/1ps

module wreq_issue import bus_side_pkg::*, user_side_pkg::*; #(
    parameter bus_addr_t TARGET_ADDR = 32'h0,
    parameter int        MAX_REQS    = 16
) (
    input  logic       ACLK,
    input  logic       ARESET,
    input  user_addr_t user_awaddr,
    input  user_len_t  user_awlen,
    input  logic       user_awvalid,
    output logic       user_awready,
    input  logic       type_ready,
    output logic       type_push,
    output logic       type_valid,
    input  logic       offset_room,
    output bus_addr_t  aw_addr,
    output bus_len_t   aw_len,
    output logic       aw_fire,
    output logic       bus_awvalid,
    input  logic       bus_awready
);

    // base forced onto a word boundary
    localparam bus_addr_t BASE = TARGET_ADDR & ({32{1'b1}} << USER_ALIGN);

    user_addr_t wreq_addr;
    user_len_t  wreq_len;
    logic       wreq_valid;
    logic       next_wreq;
    logic       ready_for_wreq;
    logic       valid_length;
    logic       aw_pending;

    sync_fifo #(
        .WIDTH   ($bits(user_len_t) + $bits(user_addr_t)),
        .DEPTH   (MAX_REQS)
    ) u_req_q (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr      (user_awvalid && user_awready),
        .din     ({user_awlen, user_awaddr}),
        .full_n  (user_awready),
        .rd      (next_wreq),
        .dout    ({wreq_len, wreq_addr}),
        .empty_n (wreq_valid)
    );

    // zero or top bit set means no bus traffic
    assign valid_length   = (wreq_len != '0) && !wreq_len[$bits(user_len_t)-1];
    assign ready_for_wreq = !aw_pending || aw_fire;
    assign next_wreq      = wreq_valid && type_ready && ready_for_wreq;
    assign type_push      = next_wreq;
    assign type_valid     = valid_length;
    assign bus_awvalid    = aw_pending && offset_room;
    assign aw_fire        = bus_awvalid && bus_awready;

    always_ff @(posedge ACLK) begin
        if (next_wreq) begin
            aw_addr <= BASE + (wreq_addr << USER_ALIGN);
            aw_len  <= (wreq_len << USER_ALIGN) - 32'd1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_pending <= 1'b0;
        end else if (next_wreq && valid_length) begin
            aw_pending <= 1'b1;
        end else if (aw_fire) begin
            aw_pending <= 1'b0;
        end
    end

    a_aw_hold: assert property (@(posedge ACLK) disable iff (ARESET)
        bus_awvalid && !bus_awready |=> bus_awvalid && $stable(aw_addr) && $stable(aw_len))
        else $error("address beat changed while stalled");

endmodule

// ==== verilog/wrsp_tracker.sv ====
`timescale 1ns/1ps

module wrsp_tracker #(
    parameter int NUM_OUTSTANDING = 2
) (
    input  logic ACLK,
    input  logic ARESET,
    input  logic type_push,
    input  logic type_valid,
    output logic type_ready,
    input  logic bus_bvalid,
    output logic bus_bready,
    output logic user_bvalid,
    input  logic user_bready
);

    logic type_avail;
    logic head_type;
    logic ursp_room;
    logic ursp_write;

    // 1 for a valid length, 0 for an invalid one
    sync_fifo #(.WIDTH(1), .DEPTH(NUM_OUTSTANDING)) u_type_q (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr      (type_push),
        .din     (type_valid),
        .full_n  (type_ready),
        .rd      (ursp_write),
        .dout    (head_type),
        .empty_n (type_avail)
    );

    sync_fifo #(.WIDTH(1), .DEPTH(NUM_OUTSTANDING)) u_ursp_q (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr      (ursp_write),
        .din     (1'b1),
        .full_n  (ursp_room),
        .rd      (user_bvalid && user_bready),
        .dout    (),
        .empty_n (user_bvalid)
    );

    // invalid entries retire without waiting on the bus
    assign ursp_write = type_avail && ursp_room && (!head_type || bus_bvalid);
    assign bus_bready = type_avail && head_type && ursp_room;

endmodule
